// File: common/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// One 8K page of address space
`define ADDR_W 13

// Shared r0 plus two banks of r1 to r3
`define NUM_REGS 7

// Opcodes that win over the group decoding
`define OP_HALT 8'h40
`define OP_NOP 8'hC0
`define OP_LPSL 8'h93
`define OP_SPSL 8'h13
`define OP_CPSL 8'h75
`define OP_PPSL 8'h77

`define PSL_RESET 8'h00

`endif

// File: common/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [`ADDR_W-1:0] addr_t;

	// First operand byte sits in the high half
	typedef logic [15:0] operand_t;

	// 00 zero, 01 positive or greater, 10 negative or less
	typedef logic [1:0] cc_t;

	typedef logic [2:0] reg_idx_t;

	// Opcode bits 7 to 5
	typedef logic [2:0] alu_op_t;

	// Bit positions in PSL, the condition code sits in bits 7 and 6
	localparam int psl_c = 0;
	localparam int psl_com = 1;
	localparam int psl_ovf = 2;
	localparam int psl_wc = 3;
	localparam int psl_rs = 4;
	localparam int psl_idc = 5;

	// Same order as opcode bits 3 to 2
	typedef enum logic [1:0] {
		mode_zero,
		mode_imm,
		mode_rel,
		mode_abs
	} mode_e;

	typedef enum logic [3:0] {
		cls_alu,
		cls_store,
		cls_compare,
		cls_br_true,
		cls_br_false,
		cls_lpsl,
		cls_spsl,
		cls_cpsl,
		cls_ppsl,
		cls_halt,
		cls_none
	} instr_class_e;

	typedef enum logic [1:0] {
		fs_opcode,
		fs_operand1,
		fs_operand2,
		fs_hold
	} fetch_state_e;

	typedef enum logic [1:0] {
		es_idle,
		es_data,
		es_halted
	} exec_state_e;

endpackage

// File: common/fetch_if.sv
`timescale 1ns/10ps

interface fetch_if;
	import cpu_pkg::*;

	logic valid;
	byte_t opcode;
	operand_t operand;
	// Address right after the instruction
	addr_t next_pc;
	logic taken;

	modport fetch_side (
		output valid,
		output opcode,
		output operand,
		output next_pc,
		input taken
	);

	modport decode_side (
		input valid,
		input opcode,
		input operand,
		input next_pc,
		output taken
	);

endinterface

// File: common/decode_if.sv
`timescale 1ns/10ps

interface decode_if;
	import cpu_pkg::*;

	logic valid;
	instr_class_e instr_class;
	mode_e mode;
	alu_op_t alu_op;
	// Register field, bank is added by execute
	logic [1:0] reg_a;
	cc_t cond;
	addr_t address;
	byte_t imm;
	logic taken;

	// Upstream end, driven by decode
	modport fetch_side (
		output valid,
		output instr_class,
		output mode,
		output alu_op,
		output reg_a,
		output cond,
		output address,
		output imm,
		input taken
	);

	modport execute_side (
		input valid,
		input instr_class,
		input mode,
		input alu_op,
		input reg_a,
		input cond,
		input address,
		input imm,
		output taken
	);

endinterface

// File: design/execute/alu.sv
`timescale 1ns/10ps

module alu (
	input cpu_pkg::alu_op_t alu_op,
	input cpu_pkg::byte_t a,
	input cpu_pkg::byte_t b,
	input cpu_pkg::byte_t psl_in,
	output cpu_pkg::byte_t result,
	output logic carry,
	output logic idc,
	output logic ovf,
	output cpu_pkg::cc_t cc_result,
	output cpu_pkg::cc_t cc_compare
);
	import cpu_pkg::*;

	localparam alu_op_t op_eor = 3'd1;
	localparam alu_op_t op_and = 3'd2;
	localparam alu_op_t op_ior = 3'd3;
	localparam alu_op_t op_add = 3'd4;
	localparam alu_op_t op_sub = 3'd5;

	localparam cc_t cc_zero = 2'b00;
	localparam cc_t cc_pos = 2'b01;
	localparam cc_t cc_neg = 2'b10;

	logic is_sub;
	logic is_arith;
	logic cin;
	byte_t b_eff;
	logic [8:0] sum;
	logic [4:0] low_sum;

	assign is_sub = alu_op == op_sub;
	assign is_arith = alu_op == op_add || is_sub;
	assign b_eff = is_sub ? ~b : b;
	// Without WC a subtract starts with no borrow
	assign cin = psl_in[psl_wc] ? psl_in[psl_c] : is_sub;
	assign sum = {1'b0, a} + {1'b0, b_eff} + {8'h00, cin};
	assign low_sum = {1'b0, a[3:0]} + {1'b0, b_eff[3:0]} + {4'h0, cin};

	always_comb begin
		carry = psl_in[psl_c];
		case (alu_op)
			op_eor: result = a ^ b;
			op_and: result = a & b;
			op_ior: result = a | b;
			op_add, op_sub: begin
				result = sum[7:0];
				carry = sum[8];
			end
			default: result = b;
		endcase
	end

	assign idc = is_arith ? low_sum[4] : psl_in[psl_idc];
	assign ovf = is_arith ? (a[7] == b_eff[7] && sum[7] != a[7]) : psl_in[psl_ovf];

	assign cc_result = result[7] ? cc_neg : ((result == 8'h00) ? cc_zero : cc_pos);

	always_comb begin
		if (a == b) begin
			cc_compare = cc_zero;
		end else if (psl_in[psl_com] || a[7] == b[7]) begin
			cc_compare = (a > b) ? cc_pos : cc_neg;
		end else begin
			// Signs differ, the negative one is less
			cc_compare = a[7] ? cc_neg : cc_pos;
		end
	end

endmodule

// File: design/execute/execute_stage.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module execute_stage (
	input logic clk,
	input logic arst_n,
	decode_if.execute_side di,
	output logic dbus_rd,
	output logic dbus_wr,
	output cpu_pkg::addr_t dbus_addr,
	output cpu_pkg::byte_t dbus_wdata,
	input cpu_pkg::byte_t dbus_rdata,
	input logic dbus_ready,
	output logic redirect,
	output cpu_pkg::addr_t target,
	output cpu_pkg::byte_t psl,
	output logic halted
);
	import cpu_pkg::*;

	byte_t regs [`NUM_REGS];
	exec_state_e state;
	reg_idx_t ra_idx;
	reg_idx_t dest_idx;
	byte_t r0;
	byte_t ra;
	byte_t alu_a;
	byte_t alu_b;
	byte_t alu_result;
	logic alu_carry;
	logic alu_idc;
	logic alu_ovf;
	cc_t cc_result;
	cc_t cc_compare;
	logic uses_mem;
	logic take_now;
	logic retire;
	logic br_take;

	// Field zero is the shared r0, fields 1 to 3 pick the bank given by RS
	assign ra_idx = (di.reg_a == 2'b00) ? 3'd0 : {1'b0, di.reg_a} + (psl[psl_rs] ? 3'd3 : 3'd0);
	assign dest_idx = (di.mode == mode_zero) ? 3'd0 : ra_idx;
	assign r0 = regs[0];
	assign ra = regs[ra_idx];

	assign uses_mem = (di.mode == mode_rel || di.mode == mode_abs)
		&& (di.instr_class == cls_alu || di.instr_class == cls_store
		|| di.instr_class == cls_compare);
	assign take_now = di.valid && state == es_idle && !uses_mem;
	assign retire = take_now || (state == es_data && dbus_ready);
	assign di.taken = retire;

	// Register-zero forms work on r0 against the named register
	assign alu_a = (di.mode == mode_zero) ? r0 : ra;

	always_comb begin
		if (di.instr_class == cls_spsl) begin
			alu_b = psl;
		end else if (di.instr_class == cls_store) begin
			alu_b = r0;
		end else begin
			case (di.mode)
				mode_zero: alu_b = ra;
				mode_imm: alu_b = di.imm;
				default: alu_b = dbus_rdata;
			endcase
		end
	end

	alu alu_i (
		.alu_op(di.alu_op),
		.a(alu_a),
		.b(alu_b),
		.psl_in(psl),
		.result(alu_result),
		.carry(alu_carry),
		.idc(alu_idc),
		.ovf(alu_ovf),
		.cc_result(cc_result),
		.cc_compare(cc_compare)
	);

	// Field 3 on a true-branch means always
	assign br_take = (di.instr_class == cls_br_true && (psl[7:6] == di.cond || di.cond == 2'b11))
		|| (di.instr_class == cls_br_false && psl[7:6] != di.cond);
	assign redirect = take_now && br_take;
	assign target = di.address;
	assign halted = state == es_halted;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= es_idle;
			dbus_rd <= 1'b0;
			dbus_wr <= 1'b0;
		end else begin
			case (state)
				es_idle: begin
					if (di.valid && uses_mem) begin
						state <= es_data;
						dbus_rd <= di.instr_class != cls_store;
						dbus_wr <= di.instr_class == cls_store;
					end else if (di.valid && di.instr_class == cls_halt) begin
						state <= es_halted;
					end
				end
				es_data: begin
					if (dbus_ready) begin
						state <= es_idle;
						dbus_rd <= 1'b0;
						dbus_wr <= 1'b0;
					end
				end
				default: begin
					// Stays halted until reset
					state <= es_halted;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == es_idle && di.valid && uses_mem) begin
			dbus_addr <= di.address;
			dbus_wdata <= ra;
		end
	end

	always_ff @(posedge clk) begin
		if (retire) begin
			case (di.instr_class)
				cls_alu: regs[dest_idx] <= alu_result;
				cls_store: begin
					if (di.mode == mode_zero) begin
						regs[ra_idx] <= r0;
					end
				end
				cls_spsl: regs[0] <= psl;
				default: regs[0] <= r0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			psl <= `PSL_RESET;
		end else if (retire) begin
			case (di.instr_class)
				cls_alu: begin
					psl[7:6] <= cc_result;
					psl[psl_idc] <= alu_idc;
					psl[psl_ovf] <= alu_ovf;
					psl[psl_c] <= alu_carry;
				end
				cls_store: begin
					if (di.mode == mode_zero) begin
						psl[7:6] <= cc_result;
					end
				end
				cls_compare: psl[7:6] <= cc_compare;
				cls_lpsl: psl <= r0;
				cls_spsl: psl[7:6] <= cc_result;
				cls_cpsl: psl <= psl & ~di.imm;
				cls_ppsl: psl <= psl | di.imm;
				default: psl <= psl;
			endcase
		end
	end

	a_bus_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(dbus_rd && dbus_wr));

endmodule

// File: design/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage (
	input logic clk,
	input logic arst_n,
	output logic ibus_rd,
	output cpu_pkg::addr_t ibus_addr,
	input cpu_pkg::byte_t ibus_rdata,
	input logic ibus_ready,
	input logic redirect,
	input cpu_pkg::addr_t target,
	fetch_if.fetch_side fi
);
	import cpu_pkg::*;

	fetch_state_e state;
	addr_t pc;
	logic read_done;

	assign read_done = ibus_rd && ibus_ready;
	assign ibus_addr = pc;
	// pc has moved past the last byte once the instruction is complete
	assign fi.next_pc = pc;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= fs_opcode;
			pc <= '0;
			ibus_rd <= 1'b0;
			fi.valid <= 1'b0;
		end else if (redirect) begin
			state <= fs_opcode;
			pc <= target;
			ibus_rd <= 1'b1;
			fi.valid <= 1'b0;
		end else begin
			case (state)
				fs_opcode: begin
					ibus_rd <= 1'b1;
					if (read_done) begin
						pc <= pc + 1'b1;
						if (ibus_rdata[3:2] == 2'b00) begin
							state <= fs_hold;
							ibus_rd <= 1'b0;
							fi.valid <= 1'b1;
						end else begin
							state <= fs_operand1;
						end
					end
				end
				fs_operand1: begin
					if (read_done) begin
						pc <= pc + 1'b1;
						// Absolute mode carries a second operand byte
						if (fi.opcode[3:2] == 2'b11) begin
							state <= fs_operand2;
						end else begin
							state <= fs_hold;
							ibus_rd <= 1'b0;
							fi.valid <= 1'b1;
						end
					end
				end
				fs_operand2: begin
					if (read_done) begin
						pc <= pc + 1'b1;
						state <= fs_hold;
						ibus_rd <= 1'b0;
						fi.valid <= 1'b1;
					end
				end
				default: begin
					if (fi.taken) begin
						state <= fs_opcode;
						ibus_rd <= 1'b1;
						fi.valid <= 1'b0;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (read_done) begin
			case (state)
				fs_opcode: fi.opcode <= ibus_rdata;
				fs_operand1: fi.operand[15:8] <= ibus_rdata;
				fs_operand2: fi.operand[7:0] <= ibus_rdata;
				default: fi.operand <= fi.operand;
			endcase
		end
	end

	a_addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
		ibus_rd && !ibus_ready && !redirect |=> $stable(ibus_addr));

endmodule

// File: design/decode_stage.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module decode_stage (
	input logic clk,
	input logic arst_n,
	input logic redirect,
	fetch_if.decode_side fi,
	decode_if.fetch_side di
);
	import cpu_pkg::*;

	instr_class_e cls;
	mode_e mode;
	addr_t rel_addr;
	logic accept;

	assign mode = mode_e'(fi.opcode[3:2]);
	assign accept = fi.valid && (!di.valid || di.taken);
	assign fi.taken = accept;

	// 7-bit signed offset, bit 7 would be the indirect flag
	assign rel_addr = fi.next_pc + {{(`ADDR_W-7){fi.operand[14]}}, fi.operand[14:8]};

	always_comb begin
		cls = cls_none;
		case (fi.opcode)
			`OP_HALT: cls = cls_halt;
			`OP_NOP: cls = cls_none;
			`OP_LPSL: cls = cls_lpsl;
			`OP_SPSL: cls = cls_spsl;
			`OP_CPSL: cls = cls_cpsl;
			`OP_PPSL: cls = cls_ppsl;
			default: begin
				if (fi.opcode[4:3] == 2'b11) begin
					// BCTR/BCTA and BCFR/BCFA only
					if (fi.opcode[7:4] == 4'h1) begin
						cls = cls_br_true;
					end else if (fi.opcode[7:4] == 4'h9) begin
						cls = cls_br_false;
					end
				end else if (!fi.opcode[4]) begin
					case (fi.opcode[7:5])
						3'd6: cls = (mode == mode_imm) ? cls_none : cls_store;
						3'd7: cls = cls_compare;
						default: cls = cls_alu;
					endcase
				end
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			di.valid <= 1'b0;
		end else if (redirect) begin
			di.valid <= 1'b0;
		end else if (accept) begin
			di.valid <= 1'b1;
		end else if (di.taken) begin
			di.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			di.instr_class <= cls;
			di.mode <= mode;
			di.alu_op <= fi.opcode[7:5];
			di.reg_a <= fi.opcode[1:0];
			di.cond <= fi.opcode[1:0];
			di.imm <= fi.operand[15:8];
			if (mode == mode_abs) begin
				di.address <= fi.operand[`ADDR_W-1:0];
			end else begin
				di.address <= rel_addr;
			end
		end
	end

	// Fetch must keep its instruction steady until decode takes it
	a_fetch_holds: assert property (@(posedge clk) disable iff (!arst_n)
		fi.valid && !fi.taken && !redirect |=> fi.valid && $stable(fi.opcode));

endmodule

// File: design/cpu_top.sv
`timescale 1ns/10ps

module cpu_top (
	input logic clk,
	input logic arst_n,
	output logic ibus_rd,
	output cpu_pkg::addr_t ibus_addr,
	input cpu_pkg::byte_t ibus_rdata,
	input logic ibus_ready,
	output logic dbus_rd,
	output logic dbus_wr,
	output cpu_pkg::addr_t dbus_addr,
	output cpu_pkg::byte_t dbus_wdata,
	input cpu_pkg::byte_t dbus_rdata,
	input logic dbus_ready,
	output cpu_pkg::byte_t psl,
	output logic halted
);
	import cpu_pkg::*;

	logic redirect;
	addr_t target;

	fetch_if fi_bus ();
	decode_if di_bus ();

	fetch_stage fetch_i (
		.clk(clk),
		.arst_n(arst_n),
		.ibus_rd(ibus_rd),
		.ibus_addr(ibus_addr),
		.ibus_rdata(ibus_rdata),
		.ibus_ready(ibus_ready),
		.redirect(redirect),
		.target(target),
		.fi(fi_bus.fetch_side)
	);

	decode_stage decode_i (
		.clk(clk),
		.arst_n(arst_n),
		.redirect(redirect),
		.fi(fi_bus.decode_side),
		.di(di_bus.fetch_side)
	);

	execute_stage execute_i (
		.clk(clk),
		.arst_n(arst_n),
		.di(di_bus.execute_side),
		.dbus_rd(dbus_rd),
		.dbus_wr(dbus_wr),
		.dbus_addr(dbus_addr),
		.dbus_wdata(dbus_wdata),
		.dbus_rdata(dbus_rdata),
		.dbus_ready(dbus_ready),
		.redirect(redirect),
		.target(target),
		.psl(psl),
		.halted(halted)
	);

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
	parameter real PERIOD = 40.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2.0) clk = ~clk;
		end
	end

endmodule

// File: verification/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;
	import cpu_pkg::*;

	localparam int NUM_TESTS = 4;
	localparam int RUN_TIMEOUT = 3000;
	localparam int RESET_CYCLES = 8;

	logic clk;
	logic arst_n;
	logic ibus_rd;
	addr_t ibus_addr;
	byte_t ibus_rdata;
	logic ibus_ready;
	logic dbus_rd;
	logic dbus_wr;
	addr_t dbus_addr;
	byte_t dbus_wdata;
	byte_t dbus_rdata;
	logic dbus_ready;
	byte_t psl;
	logic halted;

	byte_t mem [256];
	logic stall_en;
	logic [31:0] rnd;
	int errors;
	int halt_writes;
	int wr_addr_q [$];
	int wr_data_q [$];
	int tok_q [$];

	// Code bytes ("@xx" moves the load address), expected writes as address/data pairs
	string code_tbl [NUM_TESTS];
	string wr_tbl [NUM_TESTS];
	byte_t psl_tbl [NUM_TESTS];

	tb_clock #(.PERIOD(40.0)) clock_i (.clk(clk));

	cpu_top dut_i (
		.clk(clk),
		.arst_n(arst_n),
		.ibus_rd(ibus_rd),
		.ibus_addr(ibus_addr),
		.ibus_rdata(ibus_rdata),
		.ibus_ready(ibus_ready),
		.dbus_rd(dbus_rd),
		.dbus_wr(dbus_wr),
		.dbus_addr(dbus_addr),
		.dbus_wdata(dbus_wdata),
		.dbus_rdata(dbus_rdata),
		.dbus_ready(dbus_ready),
		.psl(psl),
		.halted(halted)
	);

	// One memory behind both ports, 256 bytes
	assign ibus_rdata = mem[ibus_addr[7:0]];
	// Data bytes only come back during a read
	assign dbus_rdata = dbus_rd ? mem[dbus_addr[7:0]] : 8'hxx;

	always @(posedge clk) begin
		if (arst_n && dbus_wr && dbus_ready) begin
			mem[dbus_addr[7:0]] <= dbus_wdata;
			wr_addr_q.push_back(int'(dbus_addr));
			wr_data_q.push_back(int'(dbus_wdata));
			if (halted) begin
				halt_writes++;
			end
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	always @(negedge clk) begin
		if (stall_en) begin
			rnd = xorshift(rnd);
			ibus_ready <= rnd[0] | rnd[3];
			dbus_ready <= rnd[5] | rnd[9];
		end else begin
			ibus_ready <= 1'b1;
			dbus_ready <= 1'b1;
		end
	end

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// Splits a string of hex tokens, an "@" token gets bit 16 set
	task automatic split_hex(input string s);
		string tok;
		string rest;
		int start;
		int i;
		tok_q.delete();
		start = 0;
		for (i = 0; i <= s.len(); i++) begin
			if (i == s.len() || s[i] == " ") begin
				if (i > start) begin
					tok = s.substr(start, i - 1);
					if (tok[0] == "@") begin
						rest = tok.substr(1, tok.len() - 1);
						tok_q.push_back(32'h10000 | rest.atohex());
					end else begin
						tok_q.push_back(tok.atohex());
					end
				end
				start = i + 1;
			end
		end
	endtask

	task automatic load_code(input int t);
		int addr;
		int i;
		for (i = 0; i < 256; i++) begin
			mem[i] = 8'h00;
		end
		split_hex(code_tbl[t]);
		addr = 0;
		foreach (tok_q[i]) begin
			if (tok_q[i][16]) begin
				addr = tok_q[i] & 8'hFF;
			end else begin
				mem[addr] = tok_q[i][7:0];
				addr++;
			end
		end
	endtask

	task automatic run_test(input int t, input logic stalls);
		int cycles;
		int i;
		@(negedge clk);
		arst_n = 1'b0;
		stall_en = stalls;
		load_code(t);
		wr_addr_q.delete();
		wr_data_q.delete();
		halt_writes = 0;
		repeat (RESET_CYCLES) @(negedge clk);
		check("ibus_rd", ibus_rd, 0);
		check("dbus_rd", dbus_rd, 0);
		check("dbus_wr", dbus_wr, 0);
		check("halted", halted, 0);
		check("psl", psl, 0);
		arst_n = 1'b1;
		// First opcode read starts right after reset at address zero
		@(negedge clk);
		check("ibus_rd", ibus_rd, 1);
		check("ibus_addr", ibus_addr, 0);
		cycles = 0;
		while (!halted && cycles < RUN_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			$display("Program %0d never reached HALT before the timeout", t);
			$display("Simulation failed");
			$fatal(1);
		end
		// Window in which a halted core must stay quiet
		repeat (20) @(negedge clk);
		split_hex(wr_tbl[t]);
		check("write count", wr_addr_q.size(), tok_q.size() / 2);
		for (i = 0; i < wr_addr_q.size(); i++) begin
			check("dbus_addr", wr_addr_q[i], tok_q[2 * i]);
			check("dbus_wdata", wr_data_q[i], tok_q[2 * i + 1]);
		end
		check("psl", psl, psl_tbl[t]);
		check("writes after halt", halt_writes, 0);
	endtask

	initial begin
		arst_n = 1'b0;
		ibus_ready = 1'b1;
		dbus_ready = 1'b1;
		stall_en = 1'b0;
		rnd = 32'd8359;
		errors = 0;
		halt_writes = 0;

		// Immediate logic ops with absolute stores
		code_tbl[0] = {"05 3C CD 00 80 25 FF CD 00 81 45 0F CD 00 82 ",
			"65 50 CD 00 83 40"};
		wr_tbl[0] = "80 3C 81 C3 82 03 83 53";
		psl_tbl[0] = 8'h40;
		// Add and subtract with WC clear and set
		code_tbl[1] = {"05 7F 85 01 CD 00 80 77 09 06 10 86 05 CE 00 81 ",
			"A6 20 CE 00 82 75 08 A6 05 CE 00 83 40"};
		wr_tbl[1] = "80 80 81 16 82 F5 83 F0";
		psl_tbl[1] = 8'hA1;
		// Bank switching, register-zero moves, relative and absolute access, SPSL and LPSL
		code_tbl[2] = {"1F 00 50 @50 04 11 05 21 77 10 05 31 C8 26 01 CC 00 81 ",
			"75 10 CD 00 82 C2 09 1A CE 00 83 CD 00 84 13 CC 00 85 0E 00 84 CE 00 86 ",
			"04 42 93 40"};
		wr_tbl[2] = "80 11 81 31 82 21 83 31 84 11 85 40 86 11";
		psl_tbl[2] = 8'h42;
		// Signed and logical compares steering conditional branches
		code_tbl[3] = {"05 80 04 AA E5 01 1A 03 CC 00 80 CC 00 81 77 02 E5 01 ",
			"9A 03 CC 00 82 99 10 CC 00 83 1D 00 23 CC 00 84 40 E4 AA 9C 00 2B ",
			"CC 00 85 40"};
		wr_tbl[3] = "81 AA 83 AA 85 AA";
		psl_tbl[3] = 8'h02;

		for (int pass = 0; pass < 2; pass++) begin
			for (int t = 0; t < NUM_TESTS; t++) begin
				run_test(t, pass == 1);
			end
		end

		if (errors == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			$display("Simulation failed");
			$fatal(1);
		end
	end

endmodule

// File: all.f
+incdir+common
common/cpu_pkg.sv
common/fetch_if.sv
common/decode_if.sv
design/execute/alu.sv
design/execute/execute_stage.sv
design/fetch_stage.sv
design/decode_stage.sv
design/cpu_top.sv
verification/tb_clock.sv
verification/cpu_tb.sv
